//--- common/trap_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// constants of the machine trap unit.
// fixed at XLEN 32, machine and user modes only.
// interrupt codes double as the mip and mie bit positions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRAP_CONSTS_SVH
`define TRAP_CONSTS_SVH

// data word width.
`define XLEN 32

// machine trap setup.
`define CSR_MSTATUS_ADDR  12'h300
`define CSR_MISA_ADDR     12'h301
`define CSR_MIE_ADDR      12'h304
`define CSR_MTVEC_ADDR    12'h305

// machine trap handling.
`define CSR_MSCRATCH_ADDR 12'h340
`define CSR_MEPC_ADDR     12'h341
`define CSR_MCAUSE_ADDR   12'h342
`define CSR_MTVAL_ADDR    12'h343
`define CSR_MIP_ADDR      12'h344

// mstatus fields, MPP is two bits wide.
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7
`define MSTATUS_MPP_LSB   11
`define MSTATUS_MPRV_BIT  17

// machine interrupt codes.
`define IRQ_MSI_CODE      3
`define IRQ_MTI_CODE      7
`define IRQ_MEI_CODE      11

// MXL of 1 means 32 bit, no extension letters reported.
`define MISA_VALUE        32'h4000_0000

`endif

//--- common/trap_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the trap unit blocks.
// only PRV_U and PRV_M are legal privilege values.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "trap_consts.svh"

package trap_pkg;

    // one data word.
    typedef logic [`XLEN-1:0] xword_t;

    // one CSR address.
    typedef logic [11:0] csr_addr_t;

    // interrupt code, wide enough for the external code 11.
    typedef logic [3:0] irq_code_t;

    // privilege levels, the supervisor encoding is not used.
    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } priv_e;

endpackage

//--- irq/irq_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interrupt synchronizers and selection.
// external lines may be asynchronous; they reach mip
// two clk cycles after sampling.
// priority is external, software, timer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "trap_consts.svh"

module irq_arbiter
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      ext_msip,
    input  logic      ext_mtip,
    input  logic      ext_meip,
    input  xword_t    mie,
    input  logic      mstatus_mie,
    input  priv_e     prv,
    output xword_t    mip,
    output logic      irq_pending,
    output irq_code_t irq_code,
    output logic      wakeup
);

    // line order is {meip, mtip, msip}.
    logic [2:0] sync_q1;
    logic [2:0] sync_q2;
    xword_t     ints_en;
    logic       global_en;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= {ext_meip, ext_mtip, ext_msip};
            sync_q2 <= sync_q1;
        end
    end

    always_comb begin
        mip = '0;
        mip[`IRQ_MSI_CODE] = sync_q2[0];
        mip[`IRQ_MTI_CODE] = sync_q2[1];
        mip[`IRQ_MEI_CODE] = sync_q2[2];
    end

    assign ints_en = mip & mie;
    assign wakeup  = |ints_en;

    // user mode always takes machine interrupts.
    assign global_en   = (prv == PRV_U) || mstatus_mie;
    assign irq_pending = global_en && wakeup;

    always_comb begin
        if (ints_en[`IRQ_MEI_CODE]) begin
            irq_code = irq_code_t'(`IRQ_MEI_CODE);
        end else if (ints_en[`IRQ_MSI_CODE]) begin
            irq_code = irq_code_t'(`IRQ_MSI_CODE);
        end else begin
            irq_code = irq_code_t'(`IRQ_MTI_CODE);
        end
    end

    a_code_valid: assert property (
        @(posedge clk) disable iff (!rstn)
        irq_pending |-> (mip[irq_code] && mie[irq_code])
    ) else $error("selected interrupt is not pending and enabled");

endmodule

//--- hdl/priv_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// privilege register and event priority.
// order is exception, interrupt, mret.
// all outputs but prv are combinational.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "trap_consts.svh"

module priv_ctrl
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      trap_en,
    input  xword_t    trap_epc,
    input  xword_t    trap_cause,
    input  xword_t    trap_val,
    input  logic      mret,
    input  logic      irq_pending,
    input  irq_code_t irq_code,
    input  xword_t    mtvec,
    input  xword_t    mepc,
    input  priv_e     mstatus_mpp,
    output priv_e     prv,
    output logic      irq_trigger,
    output logic      eret_en,
    output xword_t    trap_vec,
    output xword_t    ret_epc,
    output xword_t    cause,
    output xword_t    tval,
    output logic      entry_en,
    output logic      mret_en,
    output xword_t    entry_cause,
    output xword_t    entry_tval,
    output xword_t    entry_epc
);

    xword_t irq_cause;
    xword_t vec_offset;

    // an exception hides both the interrupt and the return.
    assign irq_trigger = irq_pending && !trap_en;
    assign eret_en     = mret && !trap_en;

    assign irq_cause = {1'b1, {(`XLEN-5){1'b0}}, irq_code};
    assign cause     = trap_en ? trap_cause : (irq_trigger ? irq_cause : '0);
    assign tval      = trap_en ? trap_val : '0;
    assign ret_epc   = mepc;

    // vectored mode only applies to interrupts.
    assign vec_offset = (irq_trigger && mtvec[0]) ? {{(`XLEN-6){1'b0}}, irq_code, 2'b00} : '0;
    assign trap_vec   = {mtvec[`XLEN-1:2], 2'b00} + vec_offset;

    assign entry_en    = trap_en || irq_trigger;
    assign mret_en     = eret_en;
    assign entry_cause = cause;
    assign entry_tval  = tval;
    // return address kept word aligned.
    assign entry_epc   = {trap_epc[`XLEN-1:2], 2'b00};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prv <= PRV_M;
        end else if (entry_en) begin
            prv <= PRV_M;
        end else if (mret_en) begin
            prv <= mstatus_mpp;
        end
    end

    // depends on the MPP write mask in csr_regfile.
    a_prv_legal: assert property (
        @(posedge clk) disable iff (!rstn) prv inside {PRV_U, PRV_M}
    ) else $error("illegal privilege level");

endmodule

//--- csr/csr_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine trap CSR storage.
// entry and mret updates come in as strobes, already
// prioritized against each other by priv_ctrl.
// unknown addresses read zero, mip and misa ignore writes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "trap_consts.svh"

module csr_regfile
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      csr_wr,
    input  csr_addr_t csr_waddr,
    input  xword_t    csr_wdata,
    input  csr_addr_t csr_raddr,
    input  priv_e     prv,
    input  xword_t    mip,
    input  logic      entry_en,
    input  logic      mret_en,
    input  xword_t    entry_cause,
    input  xword_t    entry_tval,
    input  xword_t    entry_epc,
    output xword_t    csr_rdata,
    output logic      mstatus_mie,
    output priv_e     mstatus_mpp,
    output logic      mprv,
    output xword_t    mie,
    output xword_t    mtvec,
    output xword_t    mepc
);

    logic   mstatus_mpie;
    logic   mie_msie;
    logic   mie_mtie;
    logic   mie_meie;
    xword_t mscratch;
    xword_t mcause;
    xword_t mtval;
    xword_t mstatus_word;

    // mstatus fields, events first, then software writes.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRV_U;
        end else if (entry_en) begin
            mstatus_mpp  <= prv;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (mret_en) begin
            mstatus_mpp  <= PRV_U;
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (csr_wr && csr_waddr == `CSR_MSTATUS_ADDR) begin
            mstatus_mie  <= csr_wdata[`MSTATUS_MIE_BIT];
            mstatus_mpie <= csr_wdata[`MSTATUS_MPIE_BIT];
            // only machine is kept, anything else falls back to user.
            mstatus_mpp  <= (csr_wdata[`MSTATUS_MPP_LSB +: 2] == 2'b11) ? PRV_M : PRV_U;
        end
    end

    // no event touches MPRV.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mprv <= 1'b0;
        end else if (csr_wr && csr_waddr == `CSR_MSTATUS_ADDR) begin
            mprv <= csr_wdata[`MSTATUS_MPRV_BIT];
        end
    end

    // software-only registers.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mie_msie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
            mtvec    <= '0;
            mscratch <= '0;
        end else if (csr_wr) begin
            if (csr_waddr == `CSR_MIE_ADDR) begin
                mie_msie <= csr_wdata[`IRQ_MSI_CODE];
                mie_mtie <= csr_wdata[`IRQ_MTI_CODE];
                mie_meie <= csr_wdata[`IRQ_MEI_CODE];
            end
            // bit 1 is reserved in the mode field.
            if (csr_waddr == `CSR_MTVEC_ADDR) begin
                mtvec <= csr_wdata & ~xword_t'(2);
            end
            if (csr_waddr == `CSR_MSCRATCH_ADDR) begin
                mscratch <= csr_wdata;
            end
        end
    end

    // trap handling registers, loaded on entry.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (entry_en) begin
            mepc   <= entry_epc;
            mcause <= entry_cause;
            mtval  <= entry_tval;
        end else if (csr_wr) begin
            if (csr_waddr == `CSR_MEPC_ADDR) begin
                mepc <= csr_wdata & ~xword_t'(3);
            end
            if (csr_waddr == `CSR_MCAUSE_ADDR) begin
                mcause <= csr_wdata;
            end
            if (csr_waddr == `CSR_MTVAL_ADDR) begin
                mtval <= csr_wdata;
            end
        end
    end

    always_comb begin
        mie = '0;
        mie[`IRQ_MSI_CODE] = mie_msie;
        mie[`IRQ_MTI_CODE] = mie_mtie;
        mie[`IRQ_MEI_CODE] = mie_meie;
    end

    always_comb begin
        mstatus_word = '0;
        mstatus_word[`MSTATUS_MIE_BIT]       = mstatus_mie;
        mstatus_word[`MSTATUS_MPIE_BIT]      = mstatus_mpie;
        mstatus_word[`MSTATUS_MPP_LSB +: 2]  = mstatus_mpp;
        mstatus_word[`MSTATUS_MPRV_BIT]      = mprv;
    end

    // read mux.
    always_comb begin
        csr_rdata = '0;
        case (csr_raddr)
            `CSR_MSTATUS_ADDR:  csr_rdata = mstatus_word;
            `CSR_MISA_ADDR:     csr_rdata = `MISA_VALUE;
            `CSR_MIE_ADDR:      csr_rdata = mie;
            `CSR_MTVEC_ADDR:    csr_rdata = mtvec;
            `CSR_MSCRATCH_ADDR: csr_rdata = mscratch;
            `CSR_MEPC_ADDR:     csr_rdata = mepc;
            `CSR_MCAUSE_ADDR:   csr_rdata = mcause;
            `CSR_MTVAL_ADDR:    csr_rdata = mtval;
            `CSR_MIP_ADDR:      csr_rdata = mip;
            default:            csr_rdata = '0;
        endcase
    end

    // entry epc arrives aligned from priv_ctrl.
    a_mepc_aligned: assert property (
        @(posedge clk) disable iff (!rstn) mepc[1:0] == 2'b00
    ) else $error("mepc lost its alignment");

endmodule

//--- hdl/trap_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine trap and CSR unit, top level.
// trap_en and mret are single-cycle strobes, no back-pressure.
// CSR writes commit at the next edge, reads are combinational.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "trap_consts.svh"

module trap_unit
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      trap_en,
    input  xword_t    trap_epc,
    input  xword_t    trap_cause,
    input  xword_t    trap_val,
    input  logic      mret,
    input  logic      ext_msip,
    input  logic      ext_mtip,
    input  logic      ext_meip,
    input  logic      csr_wr,
    input  csr_addr_t csr_waddr,
    input  xword_t    csr_wdata,
    input  csr_addr_t csr_raddr,
    output xword_t    csr_rdata,
    output xword_t    trap_vec,
    output xword_t    ret_epc,
    output xword_t    cause,
    output xword_t    tval,
    output logic      irq_trigger,
    output logic      eret_en,
    output logic      wakeup,
    output priv_e     prv,
    output logic      mprv,
    output priv_e     mpp
);

    xword_t    mip;
    xword_t    mie;
    xword_t    mtvec;
    xword_t    mepc;
    logic      mstatus_mie;
    logic      irq_pending;
    irq_code_t irq_code;
    logic      entry_en;
    logic      mret_en;
    xword_t    entry_cause;
    xword_t    entry_tval;
    xword_t    entry_epc;

    irq_arbiter u_irq_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .ext_msip    (ext_msip),
        .ext_mtip    (ext_mtip),
        .ext_meip    (ext_meip),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .prv         (prv),
        .mip         (mip),
        .irq_pending (irq_pending),
        .irq_code    (irq_code),
        .wakeup      (wakeup)
    );

    priv_ctrl u_priv_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .trap_en     (trap_en),
        .trap_epc    (trap_epc),
        .trap_cause  (trap_cause),
        .trap_val    (trap_val),
        .mret        (mret),
        .irq_pending (irq_pending),
        .irq_code    (irq_code),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mstatus_mpp (mpp),
        .prv         (prv),
        .irq_trigger (irq_trigger),
        .eret_en     (eret_en),
        .trap_vec    (trap_vec),
        .ret_epc     (ret_epc),
        .cause       (cause),
        .tval        (tval),
        .entry_en    (entry_en),
        .mret_en     (mret_en),
        .entry_cause (entry_cause),
        .entry_tval  (entry_tval),
        .entry_epc   (entry_epc)
    );

    csr_regfile u_csr_regfile (
        .clk         (clk),
        .rstn        (rstn),
        .csr_wr      (csr_wr),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .csr_raddr   (csr_raddr),
        .prv         (prv),
        .mip         (mip),
        .entry_en    (entry_en),
        .mret_en     (mret_en),
        .entry_cause (entry_cause),
        .entry_tval  (entry_tval),
        .entry_epc   (entry_epc),
        .csr_rdata   (csr_rdata),
        .mstatus_mie (mstatus_mie),
        .mstatus_mpp (mpp),
        .mprv        (mprv),
        .mie         (mie),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

endmodule

//--- testbench/trap_tests.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests, included into tb_trap_unit.
// they run in order and each one starts from the state
// the previous one left behind.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRAP_TESTS_SVH
`define TRAP_TESTS_SVH

task automatic reset_state_test();
    @(negedge clk);
    check_priv("prv", prv, PRV_M);
    check_bit("irq_trigger", irq_trigger, 1'b0);
    check_bit("eret_en", eret_en, 1'b0);
    check_bit("wakeup", wakeup, 1'b0);
    expect_csr("mstatus", `CSR_MSTATUS_ADDR, 32'h0);
    expect_csr("mtvec", `CSR_MTVEC_ADDR, 32'h0);
    expect_csr("mepc", `CSR_MEPC_ADDR, 32'h0);
    expect_csr("mcause", `CSR_MCAUSE_ADDR, 32'h0);
    expect_csr("mtval", `CSR_MTVAL_ADDR, 32'h0);
    expect_csr("misa", `CSR_MISA_ADDR, `MISA_VALUE);
endtask

task automatic csr_mask_test();
    xword_t w;
    w = $urandom();
    write_csr(`CSR_MSCRATCH_ADDR, w);
    expect_csr("mscratch", `CSR_MSCRATCH_ADDR, w);
    w = $urandom();
    write_csr(`CSR_MTVEC_ADDR, w);
    expect_csr("mtvec", `CSR_MTVEC_ADDR, w & 32'hFFFF_FFFD);
    w = $urandom();
    write_csr(`CSR_MEPC_ADDR, w);
    expect_csr("mepc", `CSR_MEPC_ADDR, w & 32'hFFFF_FFFC);
    // only bits 3, 7 and 11 exist.
    w = $urandom();
    write_csr(`CSR_MIE_ADDR, w);
    expect_csr("mie", `CSR_MIE_ADDR, w & 32'h0000_0888);
    // MPP of 01 is not legal and reads back as user.
    w = $urandom();
    w[12:11] = 2'b01;
    w[`MSTATUS_MPRV_BIT] = 1'b1;
    write_csr(`CSR_MSTATUS_ADDR, w);
    expect_csr("mstatus", `CSR_MSTATUS_ADDR, w & 32'h0002_0088);
    check_bit("mprv", mprv, 1'b1);
    w = ($urandom() | 32'h0000_1800) & ~32'h0002_0000;
    write_csr(`CSR_MSTATUS_ADDR, w);
    expect_csr("mstatus", `CSR_MSTATUS_ADDR, w & 32'h0002_1888);
    check_bit("mprv", mprv, 1'b0);
    // no line is raised yet, so mip stays clear.
    write_csr(`CSR_MIP_ADDR, $urandom());
    expect_csr("mip", `CSR_MIP_ADDR, 32'h0);
    expect_csr("mcounteren", 12'h306, 32'h0);
    expect_csr("unknown csr", 12'h7C0, 32'h0);
endtask

task automatic exception_test();
    xword_t vec;
    xword_t epc;
    xword_t tcause;
    xword_t tvalue;
    vec    = $urandom();
    epc    = $urandom();
    tcause = $urandom();
    tvalue = $urandom();
    write_csr(`CSR_MTVEC_ADDR, vec);
    // MIE set, MPP user, prv is still machine.
    write_csr(`CSR_MSTATUS_ADDR, 32'h0000_0008);
    @(posedge clk);
    trap_en    <= 1'b1;
    trap_epc   <= epc;
    trap_cause <= tcause;
    trap_val   <= tvalue;
    @(negedge clk);
    check_word("trap_vec", trap_vec, vec & 32'hFFFF_FFFC);
    check_word("cause", cause, tcause);
    check_word("tval", tval, tvalue);
    @(posedge clk);
    trap_en    <= 1'b0;
    trap_epc   <= '0;
    trap_cause <= '0;
    trap_val   <= '0;
    @(negedge clk);
    check_priv("prv", prv, PRV_M);
    expect_csr("mepc", `CSR_MEPC_ADDR, epc & 32'hFFFF_FFFC);
    expect_csr("mcause", `CSR_MCAUSE_ADDR, tcause);
    expect_csr("mtval", `CSR_MTVAL_ADDR, tvalue);
    // MPP machine, MPIE from the old MIE, MIE cleared.
    expect_csr("mstatus", `CSR_MSTATUS_ADDR, 32'h0000_1880);
endtask

task automatic mret_test();
    xword_t epc;
    epc = $urandom();
    write_csr(`CSR_MEPC_ADDR, epc);
    write_csr(`CSR_MSTATUS_ADDR, 32'h0000_0080);
    @(posedge clk);
    mret <= 1'b1;
    @(negedge clk);
    check_bit("eret_en", eret_en, 1'b1);
    check_word("ret_epc", ret_epc, epc & 32'hFFFF_FFFC);
    @(posedge clk);
    mret <= 1'b0;
    @(negedge clk);
    check_priv("prv", prv, PRV_U);
    check_priv("mpp", mpp, PRV_U);
    expect_csr("mstatus", `CSR_MSTATUS_ADDR, 32'h0000_0088);
endtask

task automatic vectored_irq_test();
    xword_t base;
    base = $urandom() & 32'hFFFF_FFFC;
    write_csr(`CSR_MTVEC_ADDR, base | 32'h1);
    write_csr(`CSR_MIE_ADDR, 32'h0000_0888);
    @(posedge clk);
    ext_mtip <= 1'b1;
    ext_meip <= 1'b1;
    wait_for_trigger(10);
    // external wins over timer with code 11.
    check_word("cause", cause, 32'h8000_000B);
    check_word("trap_vec", trap_vec, base + 32'd44);
    check_bit("wakeup", wakeup, 1'b1);
    expect_csr("mcause", `CSR_MCAUSE_ADDR, 32'h8000_000B);
    check_priv("prv", prv, PRV_M);
endtask

task automatic exception_over_irq_test();
    xword_t tcause;
    xword_t tvalue;
    tcause = $urandom();
    tvalue = $urandom();
    // setting MIE in machine mode makes the held interrupt pending.
    write_csr(`CSR_MSTATUS_ADDR, 32'h0000_0008);
    trap_en    <= 1'b1;
    trap_cause <= tcause;
    trap_val   <= tvalue;
    @(negedge clk);
    check_bit("wakeup", wakeup, 1'b1);
    check_bit("irq_trigger", irq_trigger, 1'b0);
    check_word("cause", cause, tcause);
    @(posedge clk);
    trap_en    <= 1'b0;
    trap_cause <= '0;
    trap_val   <= '0;
    expect_csr("mtval", `CSR_MTVAL_ADDR, tvalue);
    expect_csr("mcause", `CSR_MCAUSE_ADDR, tcause);
    @(posedge clk);
    ext_mtip <= 1'b0;
    ext_meip <= 1'b0;
endtask

`endif

//--- testbench/tb_trap_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for trap_unit.
// inputs change on the rising edge, outputs are sampled
// on the falling edge. the run stops at the first mismatch.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "trap_consts.svh"

module tb_trap_unit
    import trap_pkg::*;
();

    logic      clk;
    logic      rstn;
    logic      trap_en;
    xword_t    trap_epc;
    xword_t    trap_cause;
    xword_t    trap_val;
    logic      mret;
    logic      ext_msip;
    logic      ext_mtip;
    logic      ext_meip;
    logic      csr_wr;
    csr_addr_t csr_waddr;
    xword_t    csr_wdata;
    csr_addr_t csr_raddr;
    xword_t    csr_rdata;
    xword_t    trap_vec;
    xword_t    ret_epc;
    xword_t    cause;
    xword_t    tval;
    logic      irq_trigger;
    logic      eret_en;
    logic      wakeup;
    priv_e     prv;
    logic      mprv;
    priv_e     mpp;

    trap_unit u_trap_unit (
        .clk         (clk),
        .rstn        (rstn),
        .trap_en     (trap_en),
        .trap_epc    (trap_epc),
        .trap_cause  (trap_cause),
        .trap_val    (trap_val),
        .mret        (mret),
        .ext_msip    (ext_msip),
        .ext_mtip    (ext_mtip),
        .ext_meip    (ext_meip),
        .csr_wr      (csr_wr),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .trap_vec    (trap_vec),
        .ret_epc     (ret_epc),
        .cause       (cause),
        .tval        (tval),
        .irq_trigger (irq_trigger),
        .eret_en     (eret_en),
        .wakeup      (wakeup),
        .prv         (prv),
        .mprv        (mprv),
        .mpp         (mpp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopping after the first failure");
    endtask

    task automatic check_word(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_priv(input string name, input priv_e got, input priv_e exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
            abort_run();
        end
    endtask

    // the write commits on the second edge.
    task automatic write_csr(input csr_addr_t addr, input xword_t data);
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_waddr <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_wr    <= 1'b0;
    endtask

    task automatic read_csr(input csr_addr_t addr, output xword_t data);
        @(posedge clk);
        csr_raddr <= addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic expect_csr(input string name, input csr_addr_t addr, input xword_t exp);
        xword_t data;
        read_csr(addr, data);
        check_word(name, data, exp);
    endtask

    // returns at the falling edge of the cycle in which irq_trigger is high.
    task automatic wait_for_trigger(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq_trigger && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!irq_trigger) begin
            $display("irq_trigger did not rise within %0d cycles", max_cycles);
            abort_run();
        end
    endtask

    `include "trap_tests.svh"

    initial begin
        void'($urandom(20613));
        rstn       = 1'b0;
        trap_en    = 1'b0;
        trap_epc   = '0;
        trap_cause = '0;
        trap_val   = '0;
        mret       = 1'b0;
        ext_msip   = 1'b0;
        ext_mtip   = 1'b0;
        ext_meip   = 1'b0;
        csr_wr     = 1'b0;
        csr_waddr  = '0;
        csr_wdata  = '0;
        csr_raddr  = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        reset_state_test();
        csr_mask_test();
        exception_test();
        mret_test();
        vectored_irq_test();
        exception_over_irq_test();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+common
+incdir+testbench
common/trap_pkg.sv
irq/irq_arbiter.sv
hdl/priv_ctrl.sv
csr/csr_regfile.sv
hdl/trap_unit.sv
testbench/tb_trap_unit.sv

//--- Bender.yml
package:
  name: trap_unit

sources:
  - include_dirs:
      - common
    files:
      - common/trap_pkg.sv
      - irq/irq_arbiter.sv
      - hdl/priv_ctrl.sv
      - csr/csr_regfile.sv
      - hdl/trap_unit.sv
  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_trap_unit.sv
